// ==== common/router_defines.svh ====
`ifndef ROUTER_DEFINES_SVH
`define ROUTER_DEFINES_SVH

// router geometry
`define ROUTER_PORTS 5          // north, south, west, east, local

// flit payload bits
`define FLIT_DATA_W 16

// downstream buffer depth in flits
`define CREDIT_MAX 4

`endif

// ==== common/router_pkg.sv ====
`include "router_defines.svh"

package router_pkg;

        // port codes, also used as the index into every per-port vector
        typedef enum logic [2:0] {
                PORT_N = 3'd0,
                PORT_S = 3'd1,
                PORT_W = 3'd2,
                PORT_E = 3'd3,
                PORT_L = 3'd4
        } port_e;

        // head and tail both set on a single-flit packet
        typedef struct packed {
                logic                    valid;
                logic                    head;
                logic                    tail;
                port_e                   nexthop;  // output requested at this router
                logic [`FLIT_DATA_W-1:0] payload;
        } flit_t;

        // one flit per port
        typedef flit_t [`ROUTER_PORTS-1:0] flit_vec_t;

        // one bit per port (requests, grants, accepts, credit returns)
        typedef logic [`ROUTER_PORTS-1:0] port_mask_t;

endpackage

// ==== rr_arbiter/rr_priority_select.sv ====
`timescale 1ns/100ps
`include "router_defines.svh"

module rr_priority_select
        import router_pkg::*;
(
        input  port_mask_t req_i,
        input  port_e      ptr_i,
        output port_mask_t grant_o
);

        localparam int N = `ROUTER_PORTS;

        logic [2*N-1:0] req_dbl;
        logic [2*N-1:0] gnt_dbl;
        port_mask_t     req_rot;
        port_mask_t     gnt_rot;

        // rotate so that ptr_i lands on bit 0
        assign req_dbl = {req_i, req_i} >> ptr_i;
        assign req_rot = req_dbl[N-1:0];

        always_comb begin
                gnt_rot = '0;
                for (int k = N - 1; k >= 0; k--) begin
                        if (req_rot[k]) begin
                                gnt_rot = port_mask_t'(1) << k;  // lowest set bit wins
                        end
                end
        end

        // rotate back where the upper copy holds the wrapped result
        assign gnt_dbl = {gnt_rot, gnt_rot} << ptr_i;
        assign grant_o = gnt_dbl[2*N-1:N];

        // the grant must land on a request and a pending request must win
        always_comb begin
                a_grant_valid : assert ($onehot0(grant_o) && ((grant_o & ~req_i) == '0)
                                        && (req_i == '0 || grant_o != '0))
                else $error("rr_priority_select grant %h for requests %h", grant_o, req_i);
        end

endmodule

// ==== rr_arbiter/out_port_arbiter.sv ====
`timescale 1ns/100ps
`include "router_defines.svh"

module out_port_arbiter
        import router_pkg::*;
#(
        parameter port_e MY_PORT = PORT_N
) (
        input  logic       clk,
        input  logic       arst_n_i,
        input  flit_vec_t  in_flits_i,
        input  logic       has_credit_i,
        output port_mask_t grant_o
);

        localparam int N = `ROUTER_PORTS;

        port_mask_t req;
        port_e      ptr_q;
        logic       lock_q;       // packet in flight on this output
        port_e      lock_idx_q;
        port_e      win_idx;
        port_e      ptr_next;
        flit_t      win_flit;

        always_comb begin
                for (int i = 0; i < N; i++) begin
                        req[i] = in_flits_i[i].valid
                                 && (in_flits_i[i].nexthop == MY_PORT)
                                 && (i != int'(MY_PORT))
                                 && (lock_q ? (i == int'(lock_idx_q)) : in_flits_i[i].head)
                                 && has_credit_i;
                end
        end

        rr_priority_select sel (
                .req_i   (req),
                .ptr_i   (ptr_q),
                .grant_o (grant_o)
        );

        // one-hot grant back to a port code
        always_comb begin
                win_idx = PORT_N;
                for (int i = 0; i < N; i++) begin
                        if (grant_o[i]) begin
                                win_idx = port_e'(i);
                        end
                end
        end

        assign win_flit = in_flits_i[win_idx];
        assign ptr_next = (win_idx == PORT_L) ? PORT_N : port_e'(3'(win_idx) + 3'd1);

        always_ff @(posedge clk or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        ptr_q      <= PORT_N;
                        lock_q     <= 1'b0;
                        lock_idx_q <= PORT_N;
                end else if (|grant_o) begin
                        if (win_flit.tail) begin
                                lock_q <= 1'b0;
                                ptr_q  <= ptr_next;  // next packet starts after the winner
                        end else if (win_flit.head) begin
                                lock_q     <= 1'b1;
                                lock_idx_q <= win_idx;
                        end
                end
        end

        // each arbiter watches the input that shares its port code
        a_no_uturn : assert property (@(posedge clk) disable iff (!arst_n_i)
                in_flits_i[MY_PORT].valid |-> in_flits_i[MY_PORT].nexthop != MY_PORT)
        else $error("input %0d routed back to itself", MY_PORT);

        // a locked source is mid-packet, so its next flit is body or tail
        a_lock_no_head : assert property (@(posedge clk) disable iff (!arst_n_i)
                lock_q && in_flits_i[lock_idx_q].valid |-> !in_flits_i[lock_idx_q].head)
        else $error("output %0d: head flit from locked input %0d", MY_PORT, lock_idx_q);

endmodule

// ==== hdl/credit_counter.sv ====
`timescale 1ns/100ps
`include "router_defines.svh"

module credit_counter (
        input  logic clk,
        input  logic arst_n_i,
        input  logic send_i,
        input  logic credit_return_i,
        output logic has_credit_o
);

        localparam int CNT_W = $clog2(`CREDIT_MAX + 1);

        logic [CNT_W-1:0] cnt_q;

        always_ff @(posedge clk or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        cnt_q <= CNT_W'(`CREDIT_MAX);
                end else begin
                        case ({send_i, credit_return_i})
                                2'b10:   cnt_q <= cnt_q - 1'b1;
                                2'b01:   cnt_q <= cnt_q + 1'b1;
                                default: cnt_q <= cnt_q;  // none, or send and return cancel
                        endcase
                end
        end

        // the flit on the output register this cycle is not yet in cnt_q
        assign has_credit_o = (cnt_q > CNT_W'(send_i));

        a_no_send_empty : assert property (@(posedge clk) disable iff (!arst_n_i)
                send_i |-> cnt_q != '0)
        else $error("credit_counter: send with no credit");

        a_no_return_full : assert property (@(posedge clk) disable iff (!arst_n_i)
                credit_return_i |-> cnt_q != CNT_W'(`CREDIT_MAX))
        else $error("credit_counter: return while all credits held");

endmodule

// ==== hdl/switch_crossbar.sv ====
`timescale 1ns/100ps
`include "router_defines.svh"

module switch_crossbar
        import router_pkg::*;
(
        input  logic                             clk,
        input  logic                             arst_n_i,
        input  flit_vec_t                        in_flits_i,
        input  port_mask_t [`ROUTER_PORTS-1:0]   grants_i,     // [output][input]
        output port_mask_t                       in_accept_o,
        output flit_vec_t                        out_flits_o
);

        localparam int N = `ROUTER_PORTS;

        flit_vec_t            mux_flits;
        flit_vec_t            out_flit_q;
        port_mask_t           out_vld_q;
        port_mask_t [N-1:0]   grants_by_in;  // [input][output]

        always_comb begin
                mux_flits = '0;
                for (int o = 0; o < N; o++) begin
                        for (int i = 0; i < N; i++) begin
                                if (grants_i[o][i]) begin
                                        mux_flits[o] = in_flits_i[i];
                                end
                        end
                end
        end

        always_ff @(posedge clk or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        out_vld_q <= '0;
                end else begin
                        for (int o = 0; o < N; o++) begin
                                out_vld_q[o] <= mux_flits[o].valid;
                        end
                end
        end

        always_ff @(posedge clk) begin
                for (int o = 0; o < N; o++) begin
                        if (mux_flits[o].valid) begin
                                out_flit_q[o] <= mux_flits[o];
                        end
                end
        end

        always_comb begin
                for (int o = 0; o < N; o++) begin
                        out_flits_o[o]       = out_flit_q[o];
                        out_flits_o[o].valid = out_vld_q[o];
                end
        end

        genvar gi, go;
        generate
                for (gi = 0; gi < N; gi++) begin : g_in
                        for (go = 0; go < N; go++) begin : g_col
                                assign grants_by_in[gi][go] = grants_i[go][gi];
                        end
                        assign in_accept_o[gi] = |grants_by_in[gi];

                        // arbiters run independently, only routing keeps them apart
                        a_single_owner : assert property (@(posedge clk) disable iff (!arst_n_i)
                                $onehot0(grants_by_in[gi]))
                        else $error("input %0d granted by outputs %h", gi, grants_by_in[gi]);
                end
        endgenerate

endmodule

// ==== hdl/router_switch_top.sv ====
`timescale 1ns/100ps
`include "router_defines.svh"

module router_switch_top
        import router_pkg::*;
(
        input  logic       clk,
        input  logic       arst_n_i,
        input  flit_vec_t  in_flits_i,
        output port_mask_t in_accept_o,
        output flit_vec_t  out_flits_o,
        input  port_mask_t credit_return_i
);

        localparam int N = `ROUTER_PORTS;

        port_mask_t [N-1:0] grants;      // one column per output
        port_mask_t         has_credit;

        genvar p;
        generate
                for (p = 0; p < N; p++) begin : g_out
                        out_port_arbiter #(
                                .MY_PORT (port_e'(p))
                        ) arb (
                                .clk          (clk),
                                .arst_n_i     (arst_n_i),
                                .in_flits_i   (in_flits_i),
                                .has_credit_i (has_credit[p]),
                                .grant_o      (grants[p])
                        );

                        // send pulse is the registered output valid
                        credit_counter cc (
                                .clk             (clk),
                                .arst_n_i        (arst_n_i),
                                .send_i          (out_flits_o[p].valid),
                                .credit_return_i (credit_return_i[p]),
                                .has_credit_o    (has_credit[p])
                        );
                end
        endgenerate

        switch_crossbar xbar (
                .clk         (clk),
                .arst_n_i    (arst_n_i),
                .in_flits_i  (in_flits_i),
                .grants_i    (grants),
                .in_accept_o (in_accept_o),
                .out_flits_o (out_flits_o)
        );

endmodule

// ==== dv/tb_router_switch.sv ====
`timescale 1ns/100ps
`include "router_defines.svh"

module tb_router_switch
        import router_pkg::*;
();

        localparam int N = `ROUTER_PORTS;

        logic       clk = 1'b0;
        logic       arst_n_i = 1'b0;
        flit_vec_t  in_flits_i = '0;
        port_mask_t credit_return_i = '0;
        port_mask_t in_accept_o;
        flit_vec_t  out_flits_o;

        flit_vec_t   nxt_flits;        // applied at the next rising edge
        port_mask_t  nxt_ret;
        logic [31:0] rng;

        // packet generator per input
        int                      pkt_cnt [N];
        int                      fix_dst [N];   // -1 picks a random output
        int                      fix_len [N];   // 0 picks a random length
        int                      left [N];
        logic [`FLIT_DATA_W-4:0] seq [N];

        // reference arbiter and credit state per output
        int    m_ptr [N];
        logic  m_lock [N];
        int    m_src [N];
        int    avail [N];
        flit_t exp_q [N][$];

        // downstream buffer per output
        int   occ [N];
        logic hold_ret [N];
        logic open_pkt [N];
        int   open_src [N];

        int gen_cnt;
        int recv_cnt;
        int sent_n;

        router_switch_top dut0 (
                .clk             (clk),
                .arst_n_i        (arst_n_i),
                .in_flits_i      (in_flits_i),
                .in_accept_o     (in_accept_o),
                .out_flits_o     (out_flits_o),
                .credit_return_i (credit_return_i)
        );

        always #5 clk = ~clk;

        always @(posedge clk) begin
                in_flits_i      <= nxt_flits;
                credit_return_i <= nxt_ret;
        end

        function automatic logic [31:0] xorshift32(input logic [31:0] x);
                logic [31:0] y;
                y = x ^ (x << 13);
                y = y ^ (y >> 17);
                y = y ^ (y << 5);
                return y;
        endfunction

        // first requester at or after the pointer or -1 when nobody asks
        function automatic int rr_winner(input port_mask_t req, input int ptr);
                int idx;
                for (int k = 0; k < N; k++) begin
                        idx = (ptr + k) % N;
                        if (req[idx]) return idx;
                end
                return -1;
        endfunction

        function automatic flit_t make_flit(input int src, input port_e dst, input logic head,
                                            input logic tail);
                flit_t f;
                f.valid   = 1'b1;
                f.head    = head;
                f.tail    = tail;
                f.nexthop = dst;
                f.payload = {3'(src), seq[src]};   // source above the sequence number
                seq[src]++;
                gen_cnt++;
                return f;
        endfunction

        function automatic logic drained();
                logic done;
                done = 1'b1;
                for (int p = 0; p < N; p++) begin
                        if (pkt_cnt[p] != 0 || nxt_flits[p].valid || avail[p] != `CREDIT_MAX) begin
                                done = 1'b0;
                        end
                end
                return done;
        endfunction

        task automatic report_failure(input string msg);
                $display("%s", msg);
                $display("TESTS FAILED");
                $fatal(1, "simulation stopped at the first error");
        endtask

        task automatic compare_flit(input string name, input flit_t got, input flit_t exp);
                if (got !== exp) begin
                        report_failure($sformatf("FAIL %s got %h exp %h", name, got, exp));
                end
        endtask

        task automatic compare_mask(input string name, input port_mask_t got, input port_mask_t exp);
                if (got !== exp) begin
                        report_failure($sformatf("FAIL %s got %h exp %h", name, got, exp));
                end
        endtask

        task automatic check_outputs();
                flit_t f;
                int    src;
                for (int o = 0; o < N; o++) begin
                        f = out_flits_o[o];
                        src = int'(f.payload[`FLIT_DATA_W-1 -: 3]);
                        if (f.valid && exp_q[o].size() == 0) begin
                                report_failure($sformatf("output %0d sent a flit never granted",
                                                         o));
                        end else if (f.valid) begin
                                compare_flit($sformatf("out_flits_o[%0d]", o), f,
                                             exp_q[o].pop_front());
                                if (f.head ? open_pkt[o]
                                           : (!open_pkt[o] || src != open_src[o])) begin
                                        report_failure($sformatf("packets interleaved on output %0d",
                                                                 o));
                                end
                                open_pkt[o] = !f.tail;
                                open_src[o] = src;
                                occ[o]++;
                                recv_cnt++;
                                sent_n += (o == int'(PORT_N)) ? 1 : 0;
                        end else if (exp_q[o].size() != 0) begin
                                report_failure($sformatf("output %0d missed a granted flit", o));
                        end
                end
        endtask

        task automatic step_traffic(input port_mask_t acc);
                flit_t f;
                int    len;
                int    dst;
                for (int i = 0; i < N; i++) begin
                        f = in_flits_i[i];
                        if (acc[i]) begin
                                left[i]--;
                                f = (left[i] > 0) ? make_flit(i, f.nexthop, 1'b0, left[i] == 1)
                                                  : '0;
                        end
                        if (!f.valid && pkt_cnt[i] > 0) begin
                                rng = xorshift32(rng);
                                len = (fix_len[i] > 0) ? fix_len[i] : 1 + int'(rng[1:0]);
                                dst = (fix_dst[i] >= 0) ? fix_dst[i]
                                                        : (i + 1 + int'(rng[9:8])) % N;
                                left[i] = len;
                                pkt_cnt[i]--;
                                f = make_flit(i, port_e'(dst), 1'b1, len == 1);
                        end
                        nxt_flits[i] = f;
                end
                for (int o = 0; o < N; o++) begin
                        rng = xorshift32(rng);
                        nxt_ret[o] = occ[o] > 0 && !hold_ret[o] && !rng[4];  // random drain
                        occ[o] -= int'(nxt_ret[o]);
                end
        endtask

        task automatic step_model();
                port_mask_t req;
                port_mask_t exp_acc;
                flit_t      f;
                int         w;
                exp_acc = '0;
                for (int o = 0; o < N; o++) begin
                        req = '0;
                        for (int i = 0; i < N; i++) begin
                                f = in_flits_i[i];
                                req[i] = f.valid && int'(f.nexthop) == o && i != o && avail[o] > 0
                                         && (m_lock[o] ? i == m_src[o] : f.head);
                        end
                        w = rr_winner(req, m_ptr[o]);
                        if (w >= 0) begin
                                f = in_flits_i[w];
                                exp_acc[w] = 1'b1;
                                exp_q[o].push_back(f);
                                avail[o]--;
                                if (f.tail) begin
                                        m_lock[o] = 1'b0;
                                        m_ptr[o]  = (w + 1) % N;
                                end else if (f.head) begin
                                        m_lock[o] = 1'b1;
                                        m_src[o]  = w;
                                end
                        end
                        avail[o] += int'(credit_return_i[o]);  // counts from the next cycle on
                end
                compare_mask("in_accept_o", in_accept_o, exp_acc);
                step_traffic(exp_acc);
        endtask

        always @(negedge clk) begin
                if (arst_n_i) begin
                        check_outputs();
                        step_model();
                end
        end

        task automatic load_input(input int p, input int pkts, input int dst, input int len);
                pkt_cnt[p] = pkts;
                fix_dst[p] = dst;
                fix_len[p] = len;
        endtask

        task automatic wait_drained(input int limit);
                int cycles;
                cycles = 0;
                while (!drained()) begin
                        @(posedge clk);
                        cycles++;
                        if (cycles > limit) begin
                                report_failure("timeout while waiting for all packets to arrive");
                        end
                end
        endtask

        task automatic wait_north_sent(input int count, input int limit);
                int cycles;
                cycles = 0;
                while (sent_n < count) begin
                        @(posedge clk);
                        cycles++;
                        if (cycles > limit) begin
                                report_failure("timeout while waiting for flits on the north output");
                        end
                end
        endtask

        initial begin
                rng = 32'h3d22;
                nxt_flits = '0;
                nxt_ret = '0;
                gen_cnt = 0;
                recv_cnt = 0;
                sent_n = 0;
                for (int p = 0; p < N; p++) begin
                        load_input(p, 0, -1, 0);
                        left[p] = 0;
                        seq[p] = '0;
                        m_ptr[p] = int'(PORT_N);
                        m_lock[p] = 1'b0;
                        m_src[p] = 0;
                        avail[p] = `CREDIT_MAX;
                        occ[p] = 0;
                        hold_ret[p] = 1'b0;
                        open_pkt[p] = 1'b0;
                        open_src[p] = 0;
                end
                repeat (4) @(posedge clk);
                arst_n_i <= 1'b1;

                // one packet per input to distinct outputs
                for (int p = 0; p < N; p++) load_input(p, 1, (p + 1) % N, 3);
                wait_drained(500);

                // four inputs fight for local while local feeds north
                for (int p = 0; p < 4; p++) load_input(p, 2, int'(PORT_L), 4);
                load_input(int'(PORT_L), 2, int'(PORT_N), 4);
                wait_drained(500);

                // north downstream stops returning credits
                hold_ret[PORT_N] = 1'b1;
                sent_n = 0;
                load_input(int'(PORT_S), 2, int'(PORT_N), 4);
                wait_north_sent(`CREDIT_MAX, 200);
                repeat (10) @(posedge clk);  // no credit left so the next head stays put
                if (sent_n != `CREDIT_MAX) begin
                        report_failure($sformatf("FAIL out_flits_o[0] count got %h exp %h",
                                                 sent_n, `CREDIT_MAX));
                end
                hold_ret[PORT_N] = 1'b0;
                wait_drained(500);
                if (sent_n != 8) begin
                        report_failure($sformatf("FAIL out_flits_o[0] count got %h exp %h",
                                                 sent_n, 8));
                end

                // all ports loaded with random traffic
                for (int p = 0; p < N; p++) load_input(p, 40, -1, 0);
                wait_drained(20000);

                if (gen_cnt == recv_cnt) begin
                        $display("TESTS PASSED");
                        $finish;
                end else begin
                        report_failure($sformatf("FAIL recv_cnt got %h exp %h", recv_cnt, gen_cnt));
                end
        end

endmodule

// ==== list.f ====
+incdir+common
common/router_pkg.sv
rr_arbiter/rr_priority_select.sv
rr_arbiter/out_port_arbiter.sv
hdl/credit_counter.sv
hdl/switch_crossbar.sv
hdl/router_switch_top.sv
dv/tb_router_switch.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then look for the fail message in sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_router_switch \
        -o tb_router_switch > build.log 2>&1 \
        && ./obj_dir/tb_router_switch > sim.log 2>&1 \
        || echo "TESTS FAILED" >> sim.log
grep -q "TESTS FAILED" sim.log && echo "simulation failed, see sim.log and build.log" && exit 1
echo "simulation passed"
exit 0
